//--- flist.f
logic/board_pkg.sv
logic/clock_mode_ctrl.sv
logic/tick_irq_gen.sv
logic/debug_word_select.sv
logic/hex_scan_display.sv
logic/port_segment_latch.sv
logic/display_out_mux.sv
logic/board_shell.sv
sim/board_shell_assert.sv
sim/board_shell_tb.sv

//--- run.sh
#!/bin/sh
# build the testbench with Verilator, run it and look for the pass line
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module board_shell_tb -f flist.f \
    && ./obj_dir/Vboard_shell_tb | tee /dev/stderr | grep "TEST RESULT: PASS" > /dev/null \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }

//--- sim/board_shell_tb.sv
`timescale 1ns/1ps

module board_shell_tb;

    localparam int tick_period   = 40;
    localparam int step_div_bits = 4;
    localparam int scan_div      = 4;
    localparam int n_rows        = 8;
    // watchdog budget in clock cycles
    localparam int row_cycles    = 16 * scan_div + 4 * tick_period;
    localparam int margin_cycles = 30 * tick_period + 400;

    // hex glyphs a..h, dot off
    localparam logic [7:0] glyph [16] = '{
        8'hfc, 8'h60, 8'hda, 8'hf2, 8'h66, 8'hb6, 8'hbe, 8'he0,
        8'hfe, 8'he6, 8'hee, 8'h3e, 8'h9c, 8'h7a, 8'h9e, 8'h8e
    };

    // one stimulus row with its expected debug number
    typedef struct packed {
        logic        slow;
        logic [1:0]  sel;
        logic [31:0] addr;
        logic [31:0] rdata;
        logic [31:0] wdata;
        logic [15:0] port0;
        logic [15:0] port1;
        logic        tick_en;
        logic [15:0] expect_num;
    } row_t;

    logic                clk;
    logic                reset_n;
    logic [7:0]          key;
    board_pkg::mem_bus_t mem_bus;
    logic [15:0]         port0;
    logic [15:0]         port1;
    logic [15:0]         port3;
    logic                port_write;
    logic [7:0]          abcdefgh;
    logic [7:0]          digit;
    logic                nmi_req;
    logic [7:0]          led;
    row_t                rows [n_rows];
    integer              seed;
    int                  errors = 0;
    int                  checks = 0;

    board_shell #(
        .tick_period   (tick_period),
        .step_div_bits (step_div_bits),
        .scan_div      (scan_div)
    ) board_shell_i (
        .clk        (clk),
        .reset_n    (reset_n),
        .key        (key),
        .mem_bus    (mem_bus),
        .port0      (port0),
        .port1      (port1),
        .port3      (port3),
        .port_write (port_write),
        .abcdefgh   (abcdefgh),
        .digit      (digit),
        .nmi_req    (nmi_req),
        .led        (led)
    );

    // --------------------
    // clock and watchdog
    // --------------------

    initial
    begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    initial
    begin
        #((n_rows * row_cycles + margin_cycles) * 4);
        $display("timeout: the tests did not finish in the expected time");
        $display("TEST RESULT: FAIL");
        $finish;
    end

    // --------------------
    // helpers
    // --------------------

    task automatic compare(input logic [31:0] got, input logic [31:0] want, input string what);
        checks++;
        if (got !== want)
        begin
            errors++;
            $display("[FAIL] %0t ns: %s, got %h expected %h", $time, what, got, want);
        end
    endtask

    task automatic wait_cycles(input int n);
        repeat (n) @(negedge clk);
    endtask

    task automatic report_test(input string name, input int err_start);
        $display("%-10s %s", name, (errors == err_start) ? "ok" : "failed");
    endtask

    // selector rule: three low halves, then the high half of addr
    function automatic logic [15:0] expected_half(input logic [1:0] sel, input row_t r);
        case (sel)
            2'd0: return r.addr[15:0];
            2'd1: return r.rdata[15:0];
            2'd2: return r.wdata[15:0];
            default: return r.addr[31:16];
        endcase
    endfunction

    // digit 0 is the low nibble, digits 4..7 dark
    function automatic logic [7:0] expected_seg(input logic [15:0] num, input int idx);
        if (idx > 3)
            return 8'h00;
        return glyph[4'(num >> (4 * idx))];
    endfunction

    task automatic fill_rows();
        for (int i = 0; i < n_rows; i++)
        begin
            rows[i].slow    = i[0];
            rows[i].sel     = i[2:1];
            rows[i].addr    = $random(seed);
            rows[i].rdata   = $random(seed);
            rows[i].wdata   = $random(seed);
            rows[i].port0   = 16'($random(seed));
            // low byte one-hot, a real digit enable
            rows[i].port1   = {8'($random(seed)), 8'(8'h01 << 3'($random(seed)))};
            rows[i].tick_en = i[1];
            rows[i].expect_num = expected_half(rows[i].sel, rows[i]);
        end
    endtask

    // step strobe seen from inside the top level
    task automatic wait_step();
        int waited;
        waited = 0;
        @(negedge clk);
        while (!board_shell_i.step && waited < (2 << step_div_bits))
        begin
            @(negedge clk);
            waited++;
        end
        if (!board_shell_i.step)
        begin
            errors++;
            $display("at %0t ns no step strobe came in slow mode", $time);
        end
    endtask

    task automatic check_active_digit(input logic [15:0] num, input string what);
        for (int i = 0; i < 8; i++)
            if (digit == 8'(1 << i))
                compare(32'(abcdefgh), 32'(expected_seg(num, i)),
                        $sformatf("%s, digit %0d", what, i));
    endtask

    // walk all eight digit positions once
    task automatic scan_check(input logic [15:0] num, input string what);
        int waited;
        for (int i = 0; i < 8; i++)
        begin
            waited = 0;
            while (digit != 8'(1 << i) && waited < 16 * scan_div)
            begin
                @(negedge clk);
                waited++;
            end
            if (digit != 8'(1 << i))
            begin
                errors++;
                $display("at %0t ns digit %0d never became active", $time, i);
            end
            else
                compare(32'(abcdefgh), 32'(expected_seg(num, i)),
                        $sformatf("%s, digit %0d", what, i));
        end
    endtask

    task automatic apply_row(input row_t r);
        key           = {5'b0_0000, r.sel, r.slow};
        mem_bus.addr  = r.addr;
        mem_bus.rdata = r.rdata;
        mem_bus.wdata = r.wdata;
        mem_bus.write = 1'b0;
        port0         = r.port0;
        port1         = r.port1;
        port3         = {15'h0000, r.tick_en};
        port_write    = 1'b1;
        @(negedge clk);
        port_write    = 1'b0;
        // mode sync plus pin register
        wait_cycles(4);
        compare(32'(led), 32'({6'b00_0000, r.tick_en, r.slow}), "led state");
        if (r.slow)
        begin
            wait_step();
            wait_cycles(3);
            scan_check(r.expect_num, "debug number");
        end
        else
        begin
            compare(32'(abcdefgh), 32'({r.port0[6:0], r.port0[7]}), "port segments");
            compare(32'(digit), 32'(r.port1[7:0]), "port digits");
        end
    endtask

    // rising edges of nmi_req over a window
    task automatic count_pulses(input int cycles, output int pulses);
        logic prev;
        pulses = 0;
        prev   = nmi_req;
        repeat (cycles)
        begin
            @(negedge clk);
            if (nmi_req && !prev)
                pulses++;
            prev = nmi_req;
        end
    endtask

    // --------------------
    // test sequence
    // --------------------

    initial
    begin
        int          err_start;
        int          pulses;
        logic [15:0] old_num;
        logic [15:0] new_num;

        seed       = 32'h9d60_8551;
        reset_n    = 1'b0;
        key        = 8'h00;
        mem_bus    = '0;
        port0      = 16'h0000;
        port1      = 16'h0000;
        port3      = 16'h0000;
        port_write = 1'b0;
        fill_rows();

        // reset
        err_start = errors;
        wait_cycles(4);
        compare(32'({abcdefgh, digit, led, nmi_req}), 32'h0, "outputs in reset");
        wait_cycles(4);
        reset_n = 1'b1;
        @(negedge clk);
        compare(32'({abcdefgh, digit, led, nmi_req}), 32'h0, "outputs after reset");
        report_test("reset", err_start);

        for (int i = 0; i < n_rows; i++)
        begin
            err_start = errors;
            apply_row(rows[i]);
            report_test($sformatf("row %0d", i), err_start);
        end

        // hold: slow mode, rdata low half
        err_start     = errors;
        key           = 8'b0000_0011;
        mem_bus.rdata = $random(seed);
        wait_cycles(4);
        wait_step();
        @(negedge clk);
        // hold window must cover the lit digits 0 to 3
        if (digit[7])
        begin
            wait_step();
            @(negedge clk);
        end
        old_num       = mem_bus.rdata[15:0];
        // every nibble differs from the captured one
        mem_bus.rdata = ~mem_bus.rdata;
        new_num       = mem_bus.rdata[15:0];
        wait_cycles(2);
        repeat (13)
        begin
            check_active_digit(old_num, "held number before step");
            @(negedge clk);
        end
        wait_step();
        wait_cycles(3);
        scan_check(new_num, "number after step");
        report_test("hold", err_start);

        // periodic tick
        err_start = errors;
        key       = 8'h00;
        port3     = 16'h0001;
        wait_cycles(2);
        compare(32'(led[1]), 32'd1, "led[1] with tick enabled");
        count_pulses(10 * tick_period, pulses);
        compare(32'(pulses >= 9 && pulses <= 11), 32'd1,
                $sformatf("tick count %0d outside 10 +- 1", pulses));
        port3 = 16'h0000;
        wait_cycles(2);
        compare(32'(led[1]), 32'd0, "led[1] with tick disabled");
        count_pulses(10 * tick_period, pulses);
        compare(32'(pulses), 32'd0, "tick count while disabled");
        report_test("tick", err_start);

        // nmi key, combinational path
        err_start = errors;
        key[7]    = 1'b1;
        #1;
        compare(32'(nmi_req), 32'd1, "nmi key with tick disabled");
        @(negedge clk);
        port3 = 16'h0001;
        #1;
        compare(32'(nmi_req), 32'd1, "nmi key with tick enabled");
        @(negedge clk);
        key[7] = 1'b0;
        port3  = 16'h0000;
        wait_cycles(2);
        compare(32'(nmi_req), 32'd0, "nmi after key release");
        report_test("nmi key", err_start);

        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0)
            $display("TEST RESULT: PASS");
        else
            $display("TEST RESULT: FAIL");
        $finish;
    end

endmodule

//--- sim/board_shell_assert.sv
`timescale 1ns/1ps

module board_shell_assert
(
    input logic       clk,
    input logic       reset_n,
    input logic [7:0] key,
    input logic       nmi_req,
    input logic [7:0] abcdefgh,
    input logic [7:0] digit
);

    // tick nmi is a single cycle, only the key holds it longer
    property nmi_single_cycle;
        @(posedge clk) disable iff (!reset_n)
        (nmi_req && !key[7]) |=> !(nmi_req && !key[7]);
    endproperty

    // at most one digit lit
    property digit_onehot;
        @(posedge clk) disable iff (!reset_n)
        $onehot0(digit);
    endproperty

    // pins dark while reset held
    property reset_pins_clear;
        @(posedge clk)
        (!reset_n && $past(!reset_n)) |-> (abcdefgh == 8'h00 && digit == 8'h00);
    endproperty

    nmi_single_cycle_a: assert property (nmi_single_cycle)
        else $error("nmi_req high two cycles without key[7]");
    digit_onehot_a: assert property (digit_onehot)
        else $error("digit not one-hot: %b", digit);
    reset_pins_clear_a: assert property (reset_pins_clear)
        else $error("display pins not zero during reset");

endmodule

bind board_shell board_shell_assert board_shell_assert_i (
    .clk      (clk),
    .reset_n  (reset_n),
    .key      (key),
    .nmi_req  (nmi_req),
    .abcdefgh (abcdefgh),
    .digit    (digit)
);

//--- logic/board_shell.sv
`timescale 1ns/1ps

module board_shell
#(
    parameter int tick_period   = 300,
    parameter int step_div_bits = 23,
    parameter int scan_div      = 1024
)
(
    input  logic                clk,
    input  logic                reset_n,
    input  logic [7:0]          key,
    input  board_pkg::mem_bus_t mem_bus,
    input  logic [15:0]         port0,
    input  logic [15:0]         port1,
    input  logic [15:0]         port3,
    input  logic                port_write,
    output logic [7:0]          abcdefgh,
    output logic [7:0]          digit,
    output logic                nmi_req,
    output logic [7:0]          led
);

    logic                    slow_mode;
    logic                    step;
    logic [15:0]             held_number;
    board_pkg::seg_pattern_t scan_pattern;
    board_pkg::seg_pattern_t port_pattern;

    // --------------------
    // mode and step
    // --------------------

    // key[0] selects slow single-step mode
    clock_mode_ctrl #(
        .step_div_bits (step_div_bits)
    ) clock_mode_ctrl_i (
        .clk       (clk),
        .reset_n   (reset_n),
        .slow_key  (key[0]),
        .slow_mode (slow_mode),
        .step      (step)
    );

    // --------------------
    // nmi
    // --------------------

    // port3[0] is the software tick enable, key[7] the manual nmi
    tick_irq_gen #(
        .tick_period (tick_period)
    ) tick_irq_gen_i (
        .clk         (clk),
        .reset_n     (reset_n),
        .tick_enable (port3[0]),
        .nmi_key     (key[7]),
        .nmi_req     (nmi_req)
    );

    // --------------------
    // display paths
    // --------------------

    // key[2:1] picks which bus half to show
    debug_word_select debug_word_select_i (
        .clk         (clk),
        .reset_n     (reset_n),
        .step        (step),
        .sel         (board_pkg::debug_sel_e'(key[2:1])),
        .bus         (mem_bus),
        .held_number (held_number)
    );

    hex_scan_display #(
        .scan_div (scan_div)
    ) hex_scan_display_i (
        .clk     (clk),
        .reset_n (reset_n),
        .number  (held_number),
        .pattern (scan_pattern)
    );

    port_segment_latch port_segment_latch_i (
        .clk        (clk),
        .reset_n    (reset_n),
        .port_write (port_write),
        .port0      (port0),
        .port1      (port1),
        .pattern    (port_pattern)
    );

    display_out_mux display_out_mux_i (
        .clk          (clk),
        .reset_n      (reset_n),
        .slow_mode    (slow_mode),
        .scan_pattern (scan_pattern),
        .port_pattern (port_pattern),
        .abcdefgh     (abcdefgh),
        .digit        (digit)
    );

    // status leds, upper six unused
    assign led = {6'b00_0000, port3[0], slow_mode};

endmodule

//--- logic/display_out_mux.sv
`timescale 1ns/1ps

module display_out_mux
(
    input  logic                    clk,
    input  logic                    reset_n,
    input  logic                    slow_mode,
    input  board_pkg::seg_pattern_t scan_pattern,
    input  board_pkg::seg_pattern_t port_pattern,
    output logic [7:0]              abcdefgh,
    output logic [7:0]              digit
);

    board_pkg::seg_pattern_t chosen;

    // debug scan in slow mode, MCU pattern otherwise
    assign chosen = slow_mode ? scan_pattern : port_pattern;

    // --------------------
    // pin register
    // --------------------

    // one flop stage so a mode change never glitches the pins
    always_ff @(posedge clk or negedge reset_n)
    begin
        if (!reset_n)
        begin
            abcdefgh <= 8'h00;
            digit    <= 8'h00;
        end
        else
        begin
            abcdefgh <= chosen.abcdefgh;
            digit    <= chosen.digit;
        end
    end

endmodule

//--- logic/port_segment_latch.sv
`timescale 1ns/1ps

module port_segment_latch
(
    input  logic                    clk,
    input  logic                    reset_n,
    input  logic                    port_write,
    input  logic [15:0]             port0,
    input  logic [15:0]             port1,
    output board_pkg::seg_pattern_t pattern
);

    // board wiring: port0[7] is the dot, goes to segment h
    logic [7:0] seg_order;

    assign seg_order = {port0[6:0], port0[7]};

    // --------------------
    // software pattern
    // --------------------

    // only low bytes of the ports reach the display
    always_ff @(posedge clk or negedge reset_n)
    begin
        if (!reset_n)
        begin
            pattern <= '0;
        end
        else if (port_write)
        begin
            pattern.abcdefgh <= seg_order;
            // digit enables map one to one
            pattern.digit    <= port1[7:0];
        end
    end

endmodule

//--- logic/hex_scan_display.sv
`timescale 1ns/1ps

module hex_scan_display
#(
    parameter int scan_div = 1024
)
(
    input  logic                    clk,
    input  logic                    reset_n,
    input  logic [15:0]             number,
    output board_pkg::seg_pattern_t pattern
);

    // prescaler counts 0 .. scan_div-1 per digit
    localparam int presc_bits = (scan_div > 1) ? $clog2(scan_div) : 1;
    localparam logic [presc_bits-1:0] presc_limit = presc_bits'(scan_div - 1);

    logic [presc_bits-1:0] presc_cnt;
    logic                  presc_wrap;
    // active digit, 0 is the rightmost
    logic [2:0]            digit_idx;
    logic [3:0]            nibble;
    logic [7:0]            segs;
    logic [7:0]            digit_hot;

    // --------------------
    // digit scan
    // --------------------

    assign presc_wrap = (presc_cnt == presc_limit);

    always_ff @(posedge clk or negedge reset_n)
    begin
        if (!reset_n)
        begin
            presc_cnt <= '0;
            digit_idx <= 3'd0;
        end
        else if (presc_wrap)
        begin
            presc_cnt <= '0;
            // wraps naturally at 8
            digit_idx <= digit_idx + 3'd1;
        end
        else
        begin
            presc_cnt <= presc_cnt + 1'b1;
        end
    end

    // --------------------
    // nibble decode
    // --------------------

    // low two index bits pick one of four nibbles
    assign nibble = 4'(number >> {digit_idx[1:0], 2'b00});

    // upper four digits stay dark
    assign segs = digit_idx[2] ? 8'h00 : board_pkg::hex_to_segments(nibble);

    assign digit_hot = 8'b0000_0001 << digit_idx;

    // registered so digit and segments change together
    always_ff @(posedge clk or negedge reset_n)
    begin
        if (!reset_n)
        begin
            pattern <= '0;
        end
        else
        begin
            pattern.abcdefgh <= segs;
            pattern.digit    <= digit_hot;
        end
    end

endmodule

//--- logic/debug_word_select.sv
`timescale 1ns/1ps

module debug_word_select
(
    input  logic                  clk,
    input  logic                  reset_n,
    input  logic                  step,
    input  board_pkg::debug_sel_e sel,
    input  board_pkg::mem_bus_t   bus,
    output logic [15:0]           held_number
);

    // each bus word seen as two halves
    board_pkg::mem_word_u addr_w;
    board_pkg::mem_word_u rdata_w;
    board_pkg::mem_word_u wdata_w;
    logic [15:0]          pick;

    assign addr_w.word  = bus.addr;
    assign rdata_w.word = bus.rdata;
    assign wdata_w.word = bus.wdata;

    // --------------------
    // half select
    // --------------------

    always_comb
    begin
        case (sel)
            board_pkg::sel_addr_lo:  pick = addr_w.half.lo;
            board_pkg::sel_rdata_lo: pick = rdata_w.half.lo;
            board_pkg::sel_wdata_lo: pick = wdata_w.half.lo;
            board_pkg::sel_addr_hi:  pick = addr_w.half.hi;
            default:                 pick = addr_w.half.lo;
        endcase
    end

    // --------------------
    // capture on step
    // --------------------

    // frozen between steps, so slow mode shows one bus state
    always_ff @(posedge clk or negedge reset_n)
    begin
        if (!reset_n)
            held_number <= 16'h0000;
        else if (step)
            held_number <= pick;
    end

endmodule

//--- logic/tick_irq_gen.sv
`timescale 1ns/1ps

module tick_irq_gen
#(
    parameter int tick_period = 300
)
(
    input  logic clk,
    input  logic reset_n,
    input  logic tick_enable,
    input  logic nmi_key,
    output logic nmi_req
);

    // counter wide enough for 0 .. tick_period-1
    localparam int cnt_bits = (tick_period > 1) ? $clog2(tick_period) : 1;
    localparam logic [cnt_bits-1:0] cnt_limit = cnt_bits'(tick_period - 1);

    logic [cnt_bits-1:0] tick_cnt;
    logic                tick_lim;
    // one-cycle tick, only while software enables it
    logic                tick_lat;

    // --------------------
    // period counter
    // --------------------

    assign tick_lim = (tick_cnt == cnt_limit);

    always_ff @(posedge clk or negedge reset_n)
    begin
        if (!reset_n)
        begin
            tick_cnt <= '0;
            tick_lat <= 1'b0;
        end
        else
        begin
            // counter never stops, enable only gates the latch
            tick_cnt <= tick_lim ? '0 : tick_cnt + 1'b1;
            if (tick_enable)
                tick_lat <= tick_lim;
            else
                tick_lat <= 1'b0;
        end
    end

    // key nmi goes straight through, no register
    assign nmi_req = tick_lat | nmi_key;

endmodule

//--- logic/clock_mode_ctrl.sv
`timescale 1ns/1ps

module clock_mode_ctrl
#(
    parameter int step_div_bits = 23
)
(
    input  logic clk,
    input  logic reset_n,
    input  logic slow_key,
    output logic slow_mode,
    output logic step
);

    // two-flop synchronizer on the mode key
    logic [1:0]               key_sync;
    // free-running divider, wrap marks one slow step
    logic [step_div_bits-1:0] div_cnt;
    logic                     div_wrap;

    // --------------------
    // mode key sync
    // --------------------

    always_ff @(posedge clk or negedge reset_n)
    begin
        if (!reset_n)
            key_sync <= 2'b00;
        else
            key_sync <= {key_sync[0], slow_key};
    end

    // level follows key two cycles later
    assign slow_mode = key_sync[1];

    // --------------------
    // step strobe
    // --------------------

    assign div_wrap = (div_cnt == {step_div_bits{1'b1}});

    always_ff @(posedge clk or negedge reset_n)
    begin
        if (!reset_n)
        begin
            div_cnt <= '0;
            step    <= 1'b0;
        end
        else
        begin
            div_cnt <= div_cnt + 1'b1;
            // slow: one pulse per wrap, fast: every cycle
            step    <= slow_mode ? div_wrap : 1'b1;
        end
    end

endmodule

//--- logic/board_pkg.sv
package board_pkg;

    // --------------------
    // exposed memory bus
    // --------------------

    // snapshot of the MCU bus as seen by the debug shell
    typedef struct packed {
        logic [31:0] addr;
        logic [31:0] rdata;
        logic [31:0] wdata;
        logic        write;
    } mem_bus_t;

    // two halves of one bus word, hi first
    typedef struct packed {
        logic [15:0] hi;
        logic [15:0] lo;
    } mem_half_t;

    // same 32 bits, read whole or split in halves
    typedef union packed {
        logic [31:0] word;
        mem_half_t   half;
    } mem_word_u;

    // debug selector from key[2:1]
    typedef enum logic [1:0] {
        sel_addr_lo  = 2'd0,
        sel_rdata_lo = 2'd1,
        sel_wdata_lo = 2'd2,
        sel_addr_hi  = 2'd3
    } debug_sel_e;

    // --------------------
    // seven segment
    // --------------------

    // segment bits a..h with a as msb, plus one-hot digit enables
    typedef struct packed {
        logic [7:0] abcdefgh;
        logic [7:0] digit;
    } seg_pattern_t;

    // hex glyphs, dot segment h always off
    function automatic logic [7:0] hex_to_segments(input logic [3:0] nibble);
        case (nibble)
            4'h0: return 8'b1111_1100;
            4'h1: return 8'b0110_0000;
            4'h2: return 8'b1101_1010;
            4'h3: return 8'b1111_0010;
            4'h4: return 8'b0110_0110;
            4'h5: return 8'b1011_0110;
            4'h6: return 8'b1011_1110;
            4'h7: return 8'b1110_0000;
            4'h8: return 8'b1111_1110;
            4'h9: return 8'b1110_0110;
            4'ha: return 8'b1110_1110;
            4'hb: return 8'b0011_1110;
            4'hc: return 8'b1001_1100;
            4'hd: return 8'b0111_1010;
            4'he: return 8'b1001_1110;
            default: return 8'b1000_1110;
        endcase
    endfunction

endpackage
